// File: design/pov_pkg.sv
package pov_pkg;

    // configuration word as received over SPI
    localparam int CONF_WIDTH = 48;

    // one bit per driver chain, same width as drv_sin
    localparam int LANES = 30;

    // base column pattern
    localparam int PATTERN_LSB = 0;
    localparam int PATTERN_MSB = 29;

    // grayscale pulses per column, bits 42..47 reserved
    localparam int GCLK_LSB = 30;
    localparam int GCLK_MSB = 41;

    // driver controller states
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        LATCH,
        GRAY
    } ctrl_state_t;

endpackage

// File: design/spi_config_rx.sv
module spi_config_rx (
    input  logic                           clock_33,
    input  logic                           nrst,
    input  logic                           spi_clk,
    input  logic                           spi_ss,
    input  logic                           spi_mosi,
    output logic                           spi_miso,
    output logic [pov_pkg::CONF_WIDTH-1:0] conf,
    output logic                           conf_valid,
    output logic                           conf_update
);
    import pov_pkg::*;

    // counter saturates one above a full frame
    localparam int CNT_W = $clog2(CONF_WIDTH + 2);

    logic [1:0]            clk_sync;
    logic [1:0]            ss_sync;
    logic [1:0]            mosi_sync;
    logic                  clk_d;
    logic                  ss_d;
    logic                  clk_rise;
    logic                  clk_fall;
    logic                  ss_fall;
    logic                  ss_rise;
    logic [CONF_WIDTH-1:0] rx_shift;
    logic [CONF_WIDTH-1:0] tx_shift;
    logic [CNT_W-1:0]      bit_cnt;

    // two-flop synchronizers, ss idles high
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            clk_sync  <= '0;
            ss_sync   <= '1;
            mosi_sync <= '0;
            clk_d     <= 1'b0;
            ss_d      <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], spi_clk};
            ss_sync   <= {ss_sync[0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            clk_d     <= clk_sync[1];
            ss_d      <= ss_sync[1];
        end
    end

    assign clk_rise = clk_sync[1] & ~clk_d;
    assign clk_fall = ~clk_sync[1] & clk_d;
    assign ss_fall  = ~ss_sync[1] & ss_d;
    assign ss_rise  = ss_sync[1] & ~ss_d;

    // mode 0, msb first
    always_ff @(posedge clock_33) begin
        if (clk_rise && !ss_sync[1]) begin
            rx_shift <= {rx_shift[CONF_WIDTH-2:0], mosi_sync[1]};
        end
    end

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt     <= '0;
            conf        <= '0;
            conf_valid  <= 1'b0;
            conf_update <= 1'b0;
            tx_shift    <= '0;
        end else begin
            conf_update <= 1'b0;
            if (ss_fall) begin
                bit_cnt <= '0;
            end else if (clk_rise && !ss_sync[1] && bit_cnt <= CNT_W'(CONF_WIDTH)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // only a frame of exactly 48 bits is taken
            if (ss_rise && bit_cnt == CNT_W'(CONF_WIDTH)) begin
                conf        <= rx_shift;
                conf_valid  <= 1'b1;
                conf_update <= 1'b1;
            end
            // readback of the active config
            if (ss_fall) begin
                tx_shift <= conf;
            end else if (clk_fall && !ss_sync[1]) begin
                tx_shift <= {tx_shift[CONF_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign spi_miso = tx_shift[CONF_WIDTH-1];

endmodule

// File: design/frame_source.sv
module frame_source #(
    parameter int WORDS_PER_COLUMN  = 16,
    parameter int COLUMNS_PER_FRAME = 8
) (
    input  logic                           clock_33,
    input  logic                           nrst,
    input  logic [pov_pkg::CONF_WIDTH-1:0] conf,
    input  logic                           conf_valid,
    input  logic                           word_ready,
    output logic                           word_valid,
    output logic                           word_last,
    output logic [pov_pkg::LANES-1:0]      word_data
);
    import pov_pkg::*;

    localparam int WORD_W = $clog2(WORDS_PER_COLUMN + 1);
    localparam int COL_W  = $clog2(COLUMNS_PER_FRAME + 1);
    localparam int ROT_W  = $clog2(LANES);

    logic [WORD_W-1:0] word_cnt;
    logic [COL_W-1:0]  col_cnt;
    logic [ROT_W-1:0]  col_rot;
    logic [ROT_W-1:0]  rot;
    logic [LANES-1:0]  pattern;
    logic [LANES-1:0]  src;
    logic              advance;
    logic              end_of_column;

    function automatic logic [LANES-1:0] rotl(input logic [LANES-1:0] value,
                                              input logic [ROT_W-1:0] amount);
        logic [2*LANES-1:0] doubled;
        doubled = {value, value} << amount;
        return doubled[2*LANES-1:LANES];
    endfunction

    // offset increment modulo the lane count
    function automatic logic [ROT_W-1:0] rot_inc(input logic [ROT_W-1:0] value);
        return (value == ROT_W'(LANES - 1)) ? '0 : value + 1'b1;
    endfunction

    // next word is produced when the output slot is free or drains now
    assign advance       = conf_valid && (!word_valid || word_ready);
    assign end_of_column = (word_cnt == WORD_W'(WORDS_PER_COLUMN - 1));
    assign src = (word_cnt == '0) ? conf[PATTERN_MSB:PATTERN_LSB] : pattern;

    always_ff @(posedge clock_33) begin
        if (advance) begin
            word_data <= rotl(src, rot);
            if (word_cnt == '0) begin
                pattern <= conf[PATTERN_MSB:PATTERN_LSB];
            end
        end
    end

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            word_valid <= 1'b0;
            word_last  <= 1'b0;
            word_cnt   <= '0;
            col_cnt    <= '0;
            col_rot    <= '0;
            rot        <= '0;
        end else if (advance) begin
            word_valid <= 1'b1;
            word_last  <= end_of_column;
            if (end_of_column) begin
                word_cnt <= '0;
                if (col_cnt == COL_W'(COLUMNS_PER_FRAME - 1)) begin
                    col_cnt <= '0;
                    col_rot <= '0;
                    rot     <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                    col_rot <= rot_inc(col_rot);
                    rot     <= rot_inc(col_rot);
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
                rot      <= rot_inc(rot);
            end
        end else if (word_ready) begin
            word_valid <= 1'b0;
        end
    end

endmodule

// File: design/driver_controller.sv
module driver_controller (
    input  logic                                       clock_33,
    input  logic                                       nrst,
    input  logic [pov_pkg::CONF_WIDTH-1:0]             conf,
    input  logic                                       word_valid,
    input  logic                                       word_last,
    input  logic [pov_pkg::LANES-1:0]                  word_data,
    output logic                                       word_ready,
    output logic                                       load,
    output logic [pov_pkg::LANES-1:0]                  load_data,
    input  logic                                       shifter_busy,
    output logic                                       gray_start,
    output logic [pov_pkg::GCLK_MSB-pov_pkg::GCLK_LSB:0] gray_count,
    input  logic                                       gray_done,
    output logic                                       drv_lat
);
    import pov_pkg::*;

    ctrl_state_t state;
    logic        last_sent;

    // words are taken only while the shifter can start a new one
    assign word_ready = (state == SHIFT) && !shifter_busy && !last_sent;
    assign load       = word_valid && word_ready;
    assign load_data  = word_data;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state      <= IDLE;
            last_sent  <= 1'b0;
            drv_lat    <= 1'b0;
            gray_start <= 1'b0;
            gray_count <= '0;
        end else begin
            drv_lat    <= 1'b0;
            gray_start <= 1'b0;
            case (state)
                IDLE: begin
                    // wait for the first configured word
                    if (word_valid) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (load && word_last) begin
                        last_sent <= 1'b1;
                    end
                    // latch once the last sclk low phase is reached
                    if (last_sent && !shifter_busy) begin
                        last_sent <= 1'b0;
                        drv_lat   <= 1'b1;
                        state     <= LATCH;
                    end
                end
                LATCH: begin
                    gray_start <= 1'b1;
                    gray_count <= conf[GCLK_MSB:GCLK_LSB];
                    state      <= GRAY;
                end
                GRAY: begin
                    // pulses and blanking run in the generator
                    if (gray_done) begin
                        state <= SHIFT;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/driver_shifter.sv
module driver_shifter (
    input  logic                      clock_33,
    input  logic                      nrst,
    input  logic                      load,
    input  logic [pov_pkg::LANES-1:0] load_data,
    output logic                      shifter_busy,
    output logic                      drv_sclk,
    output logic [pov_pkg::LANES-1:0] drv_sin
);

    // phase 1 data setup, 2 sclk high, 3 sclk low, 0 idle
    logic [1:0] phase;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            phase    <= 2'd0;
            drv_sclk <= 1'b0;
            drv_sin  <= '0;
        end else begin
            if (load) begin
                phase   <= 2'd1;
                drv_sin <= load_data;
            end else if (phase != 2'd0) begin
                // phase 3 wraps back to idle
                phase <= phase + 1'b1;
            end
            // sclk rises one cycle after sin settles
            drv_sclk <= (phase == 2'd1);
        end
    end

    // a new load is allowed during the low phase
    assign shifter_busy = (phase == 2'd1) || (phase == 2'd2);

endmodule

// File: design/gclk_generator.sv
module gclk_generator #(
    parameter int BLANK_CYCLES = 72
) (
    input  logic                                       clock_33,
    input  logic                                       nrst,
    input  logic                                       gray_start,
    input  logic [pov_pkg::GCLK_MSB-pov_pkg::GCLK_LSB:0] gray_count,
    output logic                                       drv_gclk,
    output logic                                       gray_done
);
    import pov_pkg::*;

    localparam int GCLK_W  = GCLK_MSB - GCLK_LSB + 1;
    localparam int BLANK_W = $clog2(BLANK_CYCLES + 2);

    logic [GCLK_W-1:0]  pulses_left;
    logic [BLANK_W-1:0] blank_left;
    logic               pulsing;
    logic               blanking;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            pulses_left <= '0;
            blank_left  <= '0;
            pulsing     <= 1'b0;
            blanking    <= 1'b0;
            drv_gclk    <= 1'b0;
            gray_done   <= 1'b0;
        end else begin
            gray_done <= 1'b0;
            if (gray_start) begin
                // zero count goes straight to blanking
                pulses_left <= gray_count;
                blank_left  <= BLANK_W'(BLANK_CYCLES);
                pulsing     <= (gray_count != '0);
                blanking    <= (gray_count == '0);
                drv_gclk    <= (gray_count != '0);
            end else if (pulsing) begin
                if (drv_gclk) begin
                    drv_gclk    <= 1'b0;
                    pulses_left <= pulses_left - 1'b1;
                end else if (pulses_left == '0) begin
                    pulsing  <= 1'b0;
                    blanking <= 1'b1;
                end else begin
                    drv_gclk <= 1'b1;
                end
            end else if (blanking) begin
                if (blank_left <= BLANK_W'(1)) begin
                    blanking  <= 1'b0;
                    gray_done <= 1'b1;
                end else begin
                    blank_left <= blank_left - 1'b1;
                end
            end
        end
    end

endmodule

// File: design/pov_display_top.sv
module pov_display_top #(
    parameter int WORDS_PER_COLUMN  = 16,
    parameter int COLUMNS_PER_FRAME = 8,
    parameter int BLANK_CYCLES      = 72
) (
    input  logic                      clock_33,
    input  logic                      nrst,
    input  logic                      spi_clk,
    input  logic                      spi_ss,
    input  logic                      spi_mosi,
    output logic                      spi_miso,
    output logic                      drv_sclk,
    output logic                      drv_gclk,
    output logic                      drv_lat,
    output logic [pov_pkg::LANES-1:0] drv_sin
);
    import pov_pkg::*;

    // configuration
    logic [CONF_WIDTH-1:0]      conf;
    logic                       conf_valid;

    // column word stream
    logic                       word_valid;
    logic                       word_ready;
    logic                       word_last;
    logic [LANES-1:0]           word_data;

    // shifter and grayscale control
    logic                       load;
    logic [LANES-1:0]           load_data;
    logic                       shifter_busy;
    logic                       gray_start;
    logic [GCLK_MSB-GCLK_LSB:0] gray_count;
    logic                       gray_done;

    spi_config_rx spi_config_rx_i (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .conf        (conf),
        .conf_valid  (conf_valid),
        .conf_update ()
    );

    frame_source #(
        .WORDS_PER_COLUMN  (WORDS_PER_COLUMN),
        .COLUMNS_PER_FRAME (COLUMNS_PER_FRAME)
    ) frame_source_i (
        .clock_33   (clock_33),
        .nrst       (nrst),
        .conf       (conf),
        .conf_valid (conf_valid),
        .word_ready (word_ready),
        .word_valid (word_valid),
        .word_last  (word_last),
        .word_data  (word_data)
    );

    driver_controller driver_controller_i (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .conf         (conf),
        .word_valid   (word_valid),
        .word_last    (word_last),
        .word_data    (word_data),
        .word_ready   (word_ready),
        .load         (load),
        .load_data    (load_data),
        .shifter_busy (shifter_busy),
        .gray_start   (gray_start),
        .gray_count   (gray_count),
        .gray_done    (gray_done),
        .drv_lat      (drv_lat)
    );

    driver_shifter driver_shifter_i (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .load         (load),
        .load_data    (load_data),
        .shifter_busy (shifter_busy),
        .drv_sclk     (drv_sclk),
        .drv_sin      (drv_sin)
    );

    gclk_generator #(
        .BLANK_CYCLES (BLANK_CYCLES)
    ) gclk_generator_i (
        .clock_33   (clock_33),
        .nrst       (nrst),
        .gray_start (gray_start),
        .gray_count (gray_count),
        .drv_gclk   (drv_gclk),
        .gray_done  (gray_done)
    );

endmodule

// File: dv/tb_pov_display_top.sv
module tb_pov_display_top;
    import pov_pkg::*;

    localparam int WORDS_PER_COLUMN  = 16;
    localparam int COLUMNS_PER_FRAME = 8;
    localparam int BLANK_CYCLES      = 72;
    localparam int SPI_HALF          = 8;
    localparam int COLUMN_TIMEOUT    = 400;

    logic                  clock_33;
    logic                  nrst;
    logic                  spi_clk;
    logic                  spi_ss;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic                  drv_sclk;
    logic                  drv_gclk;
    logic                  drv_lat;
    logic [LANES-1:0]      drv_sin;

    // sin words in order, sin count at each latch, gclk pulses before each latch
    logic [LANES-1:0]      sin_log[$];
    int                    col_end[$];
    int                    pulses_before[$];
    logic [CONF_WIDTH-1:0] active_conf;
    logic [CONF_WIDTH-1:0] readback;
    logic [LANES-1:0]      pattern;
    int                    base;

    pov_display_top #(
        .WORDS_PER_COLUMN  (WORDS_PER_COLUMN),
        .COLUMNS_PER_FRAME (COLUMNS_PER_FRAME),
        .BLANK_CYCLES      (BLANK_CYCLES)
    ) pov_display_top_i (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .drv_sclk (drv_sclk),
        .drv_gclk (drv_gclk),
        .drv_lat  (drv_lat),
        .drv_sin  (drv_sin)
    );

    initial clock_33 = 1'b0;
    always #2 clock_33 = ~clock_33;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0t: %s is %0h, expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [LANES-1:0] rotate_left(input logic [LANES-1:0] value,
                                                     input int amount);
        logic [LANES-1:0] result;
        result = value;
        repeat (amount) result = {result[LANES-2:0], result[LANES-1]};
        return result;
    endfunction

    // reserved bits 42..47 get random filler
    function automatic logic [CONF_WIDTH-1:0] make_conf(input logic [11:0] gray,
                                                        input logic [LANES-1:0] pat);
        return {6'($urandom), gray, pat};
    endfunction

    function automatic int last_end();
        return (col_end.size() == 0) ? 0 : col_end[col_end.size() - 1];
    endfunction

    // samples driver pins on the falling edge, where they are stable
    task automatic monitor_outputs();
        logic             sclk_prev;
        logic             gclk_prev;
        logic [LANES-1:0] sin_prev;
        int               pulses;
        sclk_prev = 1'b0;
        gclk_prev = 1'b0;
        sin_prev  = '0;
        pulses    = 0;
        forever begin
            @(negedge clock_33);
            // the chain takes the word that was set up before the sclk edge
            if (drv_sclk && !sclk_prev) begin
                sin_log.push_back(sin_prev);
            end
            if (drv_gclk && !gclk_prev) begin
                pulses++;
            end
            if (drv_lat) begin
                col_end.push_back(sin_log.size());
                pulses_before.push_back(pulses);
                pulses = 0;
            end
            sclk_prev = drv_sclk;
            gclk_prev = drv_gclk;
            sin_prev  = drv_sin;
        end
    endtask

    task automatic wait_for_latches(input int target);
        int limit;
        int cycles;
        limit  = COLUMN_TIMEOUT * (target - col_end.size() + 1);
        cycles = 0;
        while (col_end.size() < target) begin
            if (cycles >= limit) begin
                abort_run($sformatf("timeout: only %0d drv_lat pulses seen, waited for %0d",
                                    col_end.size(), target));
            end else begin
                @(posedge clock_33);
                cycles++;
            end
        end
    endtask

    task automatic wait_mid_column();
        int cycles;
        cycles = 0;
        while (sin_log.size() - last_end() != WORDS_PER_COLUMN / 2) begin
            if (cycles >= 2 * COLUMN_TIMEOUT) begin
                abort_run("timeout: no column reached the middle of its shift phase");
            end else begin
                @(posedge clock_33);
                cycles++;
            end
        end
    endtask

    // leaves ss low so a caller can choose when the frame ends
    task automatic spi_shift_bits(input logic [CONF_WIDTH-1:0] data, input int nbits,
                                  output logic [CONF_WIDTH-1:0] miso_bits);
        logic [CONF_WIDTH-1:0] bits;
        bits      = data << (CONF_WIDTH - nbits);
        miso_bits = '0;
        @(negedge clock_33);
        spi_ss  = 1'b0;
        spi_clk = 1'b0;
        repeat (nbits) begin
            spi_mosi = bits[CONF_WIDTH-1];
            bits     = bits << 1;
            repeat (SPI_HALF) @(negedge clock_33);
            miso_bits = {miso_bits[CONF_WIDTH-2:0], spi_miso};
            spi_clk   = 1'b1;
            repeat (SPI_HALF) @(negedge clock_33);
            spi_clk = 1'b0;
        end
    endtask

    task automatic spi_release();
        repeat (SPI_HALF) @(negedge clock_33);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        // conf commits a few cycles after ss rises
        repeat (SPI_HALF) @(negedge clock_33);
    endtask

    task automatic spi_send(input logic [CONF_WIDTH-1:0] data, input int nbits,
                            output logic [CONF_WIDTH-1:0] miso_bits);
        spi_shift_bits(data, nbits, miso_bits);
        spi_release();
    endtask

    task automatic apply_conf(input logic [11:0] gray, input logic [LANES-1:0] pat);
        logic [CONF_WIDTH-1:0] next_conf;
        next_conf = make_conf(gray, pat);
        spi_send(next_conf, CONF_WIDTH, readback);
        check_value("spi_miso readback", 64'(readback), 64'(active_conf));
        active_conf = next_conf;
        base        = col_end.size();
    endtask

    // column index counts from the first configuration
    task automatic check_column(input int col, input logic [LANES-1:0] pat);
        int first;
        int k;
        first = (col == 0) ? 0 : col_end[col - 1];
        check_value($sformatf("drv_sclk pulses in column %0d", col),
                    64'(col_end[col] - first), 64'(WORDS_PER_COLUMN));
        for (k = 0; k < WORDS_PER_COLUMN; k++) begin
            check_value($sformatf("drv_sin column %0d word %0d", col, k),
                        64'(sin_log[first + k]),
                        64'(rotate_left(pat, (k + col % COLUMNS_PER_FRAME) % LANES)));
        end
    endtask

    task automatic count_gray(input int count);
        wait_for_latches(base + 3);
        check_value("drv_gclk pulses", 64'(pulses_before[base + 1]), 64'(count));
        check_value("drv_gclk pulses", 64'(pulses_before[base + 2]), 64'(count));
        check_column(base + 1, pattern);
    endtask

    task automatic test_reset_idle();
        repeat (200) begin
            @(negedge clock_33);
            check_value("drv_lat", 64'(drv_lat), 64'(0));
            check_value("drv_sclk", 64'(drv_sclk), 64'(0));
            check_value("drv_gclk", 64'(drv_gclk), 64'(0));
            check_value("drv_sin", 64'(drv_sin), 64'(0));
        end
    endtask

    task automatic test_column_data();
        pattern = LANES'($urandom);
        apply_conf(12'd5, pattern);
        wait_for_latches(base + 2);
        check_column(base, pattern);
        check_column(base + 1, pattern);
    endtask

    task automatic test_gray_count();
        check_value("drv_gclk pulses before first drv_lat", 64'(pulses_before[0]), 64'(0));
        count_gray(5);
        apply_conf(12'd1, pattern);
        count_gray(1);
        apply_conf(12'd0, pattern);
        count_gray(0);
    endtask

    task automatic test_reconfiguration();
        logic [LANES-1:0]      old_pattern;
        logic [CONF_WIDTH-1:0] next_conf;
        old_pattern = pattern;
        pattern     = old_pattern ^ LANES'($urandom | 1);
        next_conf   = make_conf(12'd5, pattern);
        spi_shift_bits(next_conf, CONF_WIDTH, readback);
        check_value("spi_miso readback", 64'(readback), 64'(active_conf));
        // end the frame halfway through a shift phase
        wait_mid_column();
        base = col_end.size();
        spi_release();
        active_conf = next_conf;
        wait_for_latches(base + 2);
        check_column(base, old_pattern);
        check_column(base + 1, pattern);
    endtask

    task automatic test_frame_reject();
        logic [CONF_WIDTH-1:0] junk;
        junk = {16'h0, $urandom};
        spi_send(junk, 40, readback);
        check_value("spi_miso readback of 40-bit frame", 64'(readback),
                    64'(active_conf[CONF_WIDTH-1:8]));
        base = col_end.size();
        wait_for_latches(base + 3);
        check_column(base + 1, pattern);
        check_column(base + 2, pattern);
        spi_send(active_conf, CONF_WIDTH, readback);
        check_value("spi_miso readback", 64'(readback), 64'(active_conf));
    endtask

    task automatic test_frame_wrap();
        int j;
        base = col_end.size();
        wait_for_latches(base + COLUMNS_PER_FRAME + 2);
        // more than a full frame, so the offset wraps back to column 0
        for (j = base; j < base + COLUMNS_PER_FRAME + 2; j++) begin
            check_column(j, pattern);
        end
    endtask

    initial monitor_outputs();

    initial begin
        nrst        = 1'b0;
        spi_clk     = 1'b0;
        spi_ss      = 1'b1;
        spi_mosi    = 1'b0;
        active_conf = '0;
        base        = 0;
        void'($urandom(32'h8112_0ae7));
        repeat (5) @(negedge clock_33);
        nrst = 1'b1;
        test_reset_idle();
        test_column_data();
        test_gray_count();
        test_reconfiguration();
        test_frame_reject();
        test_frame_wrap();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: all.f
design/pov_pkg.sv
design/spi_config_rx.sv
design/frame_source.sv
design/driver_controller.sv
design/driver_shifter.sv
design/gclk_generator.sv
design/pov_display_top.sv
dv/tb_pov_display_top.sv

// File: Makefile
# Verilator build and run for the POV display testbench

VERILATOR ?= verilator
TOP       ?= tb_pov_display_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, not the simulator exit code
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
